// ==== src/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// machine word and register file shape
`define DATA_W 32
`define REG_NUM 32

// fetch starts here after reset
`define RESET_PC 32'h0000_0000

// sll r0, r0, 0
`define NOP_WORD 32'h0000_0000

`endif

// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef logic [4:0] reg_idx_t;

    // instruction views, all 32 bits wide
    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rtype_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } itype_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } jtype_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic    regwrite;
        logic    memread;
        logic    memwrite;
        logic    alusrc_imm;
        logic    regdst_rd;
        alu_op_e alu_op;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jump;
    } ctrl_word;

endpackage

`default_nettype wire

// ==== src/pipe_pkg.sv ====
`include "cpu_defines.svh"
`default_nettype none

package pipe_pkg;

    typedef logic [`DATA_W-1:0] word_t;

    typedef struct packed {
        logic f;
        logic d;
        logic e;
        logic m;
        logic w;
    } stage_vec;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_MEM  = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_e;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } ftod_t;

    typedef struct packed {
        word_t             pc;
        isa_pkg::reg_idx_t rs;
        isa_pkg::reg_idx_t rt;
        word_t             rs_data;
        word_t             rt_data;
        word_t             imm;
        isa_pkg::reg_idx_t dst;
        isa_pkg::ctrl_word ctrl;
    } dtoe_t;

    typedef struct packed {
        word_t             pc;
        word_t             alu_result;
        word_t             store_data;
        isa_pkg::reg_idx_t dst;
        isa_pkg::ctrl_word ctrl;
    } etom_t;

    typedef struct packed {
        word_t             pc;
        word_t             alu_result;
        word_t             load_data;
        isa_pkg::reg_idx_t dst;
        isa_pkg::ctrl_word ctrl;
    } mtow_t;

    // what each stage tells the hazard unit
    typedef struct packed {
        isa_pkg::reg_idx_t rs;
        isa_pkg::reg_idx_t rt;
        logic              is_branch;
    } dtoh_t;

    typedef struct packed {
        isa_pkg::reg_idx_t rs;
        isa_pkg::reg_idx_t rt;
        isa_pkg::reg_idx_t dst;
        logic              regwrite;
        logic              memread;
    } etoh_t;

    typedef struct packed {
        isa_pkg::reg_idx_t dst;
        logic              regwrite;
        logic              memread;
    } mtoh_t;

    typedef struct packed {
        isa_pkg::reg_idx_t dst;
        logic              regwrite;
    } wtoh_t;

    typedef struct packed {
        fwd_sel_e fwd_a;
        fwd_sel_e fwd_b;
    } htod_t;

    typedef struct packed {
        fwd_sel_e fwd_a;
        fwd_sel_e fwd_b;
    } htoe_t;

    // operand source chosen by the hazard unit
    function automatic word_t fwd_pick(
        input fwd_sel_e sel,
        input word_t    reg_val,
        input word_t    m_val,
        input word_t    w_val
    );
        case (sel)
            FWD_MEM: return m_val;
            FWD_WB:  return w_val;
            default: return reg_val;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/regfile.sv ====
`include "cpu_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wen,
    input  logic [4:0]         waddr,
    input  logic [`DATA_W-1:0] wdata,
    input  logic [4:0]         raddr_a,
    input  logic [4:0]         raddr_b,
    output logic [`DATA_W-1:0] rdata_a,
    output logic [`DATA_W-1:0] rdata_b
);

    logic [`DATA_W-1:0] regs [`REG_NUM];
    logic               wr_live;

    // r0 is never written
    assign wr_live = wen && (waddr != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through, decode sees the value written back this cycle
    assign rdata_a = (raddr_a == '0) ? '0 :
                     (wr_live && raddr_a == waddr) ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 :
                     (wr_live && raddr_b == waddr) ? wdata : regs[raddr_b];

endmodule

`default_nettype wire

// ==== src/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  pipe_pkg::ftod_t   ftod,
    input  pipe_pkg::word_t   rs_data,
    input  pipe_pkg::word_t   rt_data,
    input  pipe_pkg::word_t   m_result,
    input  pipe_pkg::word_t   w_result,
    input  pipe_pkg::htod_t   htod,
    output isa_pkg::reg_idx_t rs_addr,
    output isa_pkg::reg_idx_t rt_addr,
    output pipe_pkg::dtoe_t   dtoe,
    output pipe_pkg::dtoh_t   dtoh,
    output pipe_pkg::word_t   next_pc
);

    isa_pkg::rtype_t   r_view;
    isa_pkg::itype_t   i_view;
    isa_pkg::jtype_t   j_view;
    isa_pkg::ctrl_word ctrl;
    isa_pkg::reg_idx_t dst;
    pipe_pkg::word_t   imm_sext;
    pipe_pkg::word_t   rs_fwd;
    pipe_pkg::word_t   rt_fwd;
    pipe_pkg::word_t   slot_pc;
    logic              taken;

    assign r_view = ftod.instr;
    assign i_view = ftod.instr;
    assign j_view = ftod.instr;

    assign rs_addr  = r_view.rs;
    assign rt_addr  = r_view.rt;
    assign imm_sext = {{16{i_view.imm[15]}}, i_view.imm};

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = isa_pkg::ALU_ADD;
        case (isa_pkg::opcode_e'(r_view.opcode))
            isa_pkg::OP_RTYPE: begin
                ctrl.regdst_rd = 1'b1;
                ctrl.regwrite  = 1'b1;
                case (isa_pkg::funct_e'(r_view.funct))
                    isa_pkg::FN_ADDU: ctrl.alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: ctrl.alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  ctrl.alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:   ctrl.alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_SLT:  ctrl.alu_op = isa_pkg::ALU_SLT;
                    // nop and anything outside the subset
                    default:          ctrl.regwrite = 1'b0;
                endcase
            end
            isa_pkg::OP_ADDIU: begin
                ctrl.regwrite   = 1'b1;
                ctrl.alusrc_imm = 1'b1;
            end
            isa_pkg::OP_LUI: begin
                ctrl.regwrite   = 1'b1;
                ctrl.alusrc_imm = 1'b1;
                ctrl.alu_op     = isa_pkg::ALU_LUI;
            end
            isa_pkg::OP_LW: begin
                ctrl.regwrite   = 1'b1;
                ctrl.memread    = 1'b1;
                ctrl.alusrc_imm = 1'b1;
            end
            isa_pkg::OP_SW: begin
                ctrl.memwrite   = 1'b1;
                ctrl.alusrc_imm = 1'b1;
            end
            isa_pkg::OP_BEQ: ctrl.is_branch = 1'b1;
            isa_pkg::OP_BNE: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = 1'b1;
            end
            isa_pkg::OP_J:   ctrl.is_jump = 1'b1;
            default:         ctrl = '0;
        endcase
        dst = ctrl.regdst_rd ? r_view.rd : r_view.rt;
        // writes to r0 are dropped here
        if (dst == '0) begin
            ctrl.regwrite = 1'b0;
        end
    end

    assign rs_fwd = pipe_pkg::fwd_pick(htod.fwd_a, rs_data, m_result, w_result);
    assign rt_fwd = pipe_pkg::fwd_pick(htod.fwd_b, rt_data, m_result, w_result);

    assign taken   = ctrl.is_branch && ((rs_fwd == rt_fwd) ^ ctrl.branch_ne);
    assign slot_pc = ftod.pc + 32'd4;

    // targets are relative to the delay slot
    always_comb begin
        if (ctrl.is_jump) begin
            next_pc = {slot_pc[31:28], j_view.target, 2'b00};
        end else if (taken) begin
            next_pc = slot_pc + {imm_sext[29:0], 2'b00};
        end else begin
            next_pc = slot_pc + 32'd4;
        end
    end

    assign dtoe = '{pc: ftod.pc, rs: r_view.rs, rt: r_view.rt, rs_data: rs_fwd,
                    rt_data: rt_fwd, imm: imm_sext, dst: dst, ctrl: ctrl};

    assign dtoh = '{rs: r_view.rs, rt: r_view.rt, is_branch: ctrl.is_branch};

endmodule

`default_nettype wire

// ==== src/hazard.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard (
    input  pipe_pkg::dtoh_t    dtoh,
    input  pipe_pkg::etoh_t    etoh,
    input  pipe_pkg::mtoh_t    mtoh,
    input  pipe_pkg::wtoh_t    wtoh,
    output pipe_pkg::htod_t    htod,
    output pipe_pkg::htoe_t    htoe,
    output pipe_pkg::stage_vec stall,
    output pipe_pkg::stage_vec flush
);

    logic ex_dep;
    logic mem_dep;
    logic load_use;
    logic branch_dep;
    logic hold;

    function automatic logic hits(
        input isa_pkg::reg_idx_t src,
        input isa_pkg::reg_idx_t dst,
        input logic              wr
    );
        return wr && (src != '0) && (src == dst);
    endfunction

    // memory stage wins over write-back, it holds the younger value
    function automatic pipe_pkg::fwd_sel_e pick(
        input isa_pkg::reg_idx_t src,
        input logic              mem_usable,
        input pipe_pkg::mtoh_t   m,
        input pipe_pkg::wtoh_t   w
    );
        if (mem_usable && hits(src, m.dst, m.regwrite)) begin
            return pipe_pkg::FWD_MEM;
        end
        if (hits(src, w.dst, w.regwrite)) begin
            return pipe_pkg::FWD_WB;
        end
        return pipe_pkg::FWD_NONE;
    endfunction

    always_comb begin
        // a load in memory has only its address on m_result
        htod.fwd_a = pick(dtoh.rs, !mtoh.memread, mtoh, wtoh);
        htod.fwd_b = pick(dtoh.rt, !mtoh.memread, mtoh, wtoh);
        htoe.fwd_a = pick(etoh.rs, 1'b1, mtoh, wtoh);
        htoe.fwd_b = pick(etoh.rt, 1'b1, mtoh, wtoh);
    end

    assign ex_dep  = hits(dtoh.rs, etoh.dst, etoh.regwrite) ||
                     hits(dtoh.rt, etoh.dst, etoh.regwrite);
    assign mem_dep = hits(dtoh.rs, mtoh.dst, mtoh.regwrite) ||
                     hits(dtoh.rt, mtoh.dst, mtoh.regwrite);

    assign load_use   = etoh.memread && ex_dep;
    assign branch_dep = dtoh.is_branch && (ex_dep || (mtoh.memread && mem_dep));
    assign hold       = load_use || branch_dep;

    always_comb begin
        stall   = '0;
        flush   = '0;
        stall.f = hold;
        stall.d = hold;
        // bubble into execute while decode waits
        flush.e = hold;
    end

endmodule

`default_nettype wire

// ==== src/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  pipe_pkg::dtoe_t dtoe,
    input  pipe_pkg::htoe_t htoe,
    input  pipe_pkg::word_t m_result,
    input  pipe_pkg::word_t w_result,
    output pipe_pkg::etom_t etom,
    output pipe_pkg::etoh_t etoh
);

    pipe_pkg::word_t src_a;
    pipe_pkg::word_t fwd_b;
    pipe_pkg::word_t src_b;
    pipe_pkg::word_t result;

    assign src_a = pipe_pkg::fwd_pick(htoe.fwd_a, dtoe.rs_data, m_result, w_result);
    assign fwd_b = pipe_pkg::fwd_pick(htoe.fwd_b, dtoe.rt_data, m_result, w_result);
    assign src_b = dtoe.ctrl.alusrc_imm ? dtoe.imm : fwd_b;

    always_comb begin
        case (dtoe.ctrl.alu_op)
            isa_pkg::ALU_ADD: result = src_a + src_b;
            isa_pkg::ALU_SUB: result = src_a - src_b;
            isa_pkg::ALU_AND: result = src_a & src_b;
            isa_pkg::ALU_OR:  result = src_a | src_b;
            isa_pkg::ALU_SLT: result = {31'd0, $signed(src_a) < $signed(src_b)};
            // low half of the immediate moves up
            isa_pkg::ALU_LUI: result = {src_b[15:0], 16'h0000};
            default:          result = '0;
        endcase
    end

    // store data is the forwarded rt, not the immediate
    assign etom = '{pc: dtoe.pc, alu_result: result, store_data: fwd_b,
                    dst: dtoe.dst, ctrl: dtoe.ctrl};

    assign etoh = '{rs: dtoe.rs, rt: dtoe.rt, dst: dtoe.dst,
                    regwrite: dtoe.ctrl.regwrite, memread: dtoe.ctrl.memread};

endmodule

`default_nettype wire

// ==== src/datapath.sv ====
`include "cpu_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`DATA_W-1:0] instr,
    input  logic [`DATA_W-1:0] data_rdata,
    output logic [`DATA_W-1:0] pc,
    output logic               data_req,
    output logic               data_wr,
    output logic [`DATA_W-1:0] data_addr,
    output logic [`DATA_W-1:0] data_wdata,
    output logic [`DATA_W-1:0] debug_wb_pc,
    output logic               debug_rf_wen,
    output logic [4:0]         debug_rf_wnum,
    output logic [`DATA_W-1:0] debug_rf_wdata
);

    pipe_pkg::ftod_t    ftod_f;
    pipe_pkg::ftod_t    ftod_d;
    pipe_pkg::dtoe_t    dtoe_d;
    pipe_pkg::dtoe_t    dtoe_e;
    pipe_pkg::etom_t    etom_e;
    pipe_pkg::etom_t    etom_m;
    pipe_pkg::mtow_t    mtow_m;
    pipe_pkg::mtow_t    mtow_w;
    pipe_pkg::dtoh_t    dtoh_d;
    pipe_pkg::etoh_t    etoh_e;
    pipe_pkg::mtoh_t    mtoh_m;
    pipe_pkg::wtoh_t    wtoh_w;
    pipe_pkg::htod_t    htod_d;
    pipe_pkg::htoe_t    htoe_e;
    pipe_pkg::stage_vec stall;
    pipe_pkg::stage_vec flush;

    isa_pkg::reg_idx_t  rs_addr;
    isa_pkg::reg_idx_t  rt_addr;
    logic [`DATA_W-1:0] rs_data;
    logic [`DATA_W-1:0] rt_data;
    logic [`DATA_W-1:0] next_pc;
    logic [`DATA_W-1:0] pc_next;
    logic [`DATA_W-1:0] m_result;
    logic [`DATA_W-1:0] w_result;

    // fetch
    assign ftod_f = '{instr: instr, pc: pc};

    // decode only redirects for control transfers, else sequential
    assign pc_next = (dtoe_d.ctrl.is_branch || dtoe_d.ctrl.is_jump) ? next_pc
                                                                   : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (!stall.f) begin
            pc <= pc_next;
        end
    end

    regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .wen     (mtow_w.ctrl.regwrite),
        .waddr   (mtow_w.dst),
        .wdata   (w_result),
        .raddr_a (rs_addr),
        .raddr_b (rt_addr),
        .rdata_a (rs_data),
        .rdata_b (rt_data)
    );

    decode u_decode (
        .ftod     (ftod_d),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .m_result (m_result),
        .w_result (w_result),
        .htod     (htod_d),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .dtoe     (dtoe_d),
        .dtoh     (dtoh_d),
        .next_pc  (next_pc)
    );

    ex_stage u_ex_stage (
        .dtoe     (dtoe_e),
        .htoe     (htoe_e),
        .m_result (m_result),
        .w_result (w_result),
        .etom     (etom_e),
        .etoh     (etoh_e)
    );

    hazard u_hazard (
        .dtoh  (dtoh_d),
        .etoh  (etoh_e),
        .mtoh  (mtoh_m),
        .wtoh  (wtoh_w),
        .htod  (htod_d),
        .htoe  (htoe_e),
        .stall (stall),
        .flush (flush)
    );

    // memory stage, sram-like port answers in the same cycle
    assign m_result   = etom_m.alu_result;
    assign data_req   = etom_m.ctrl.memread || etom_m.ctrl.memwrite;
    assign data_wr    = etom_m.ctrl.memwrite;
    assign data_addr  = etom_m.alu_result;
    assign data_wdata = etom_m.store_data;

    assign mtow_m = '{pc: etom_m.pc, alu_result: etom_m.alu_result, load_data: data_rdata,
                      dst: etom_m.dst, ctrl: etom_m.ctrl};
    assign mtoh_m = '{dst: etom_m.dst, regwrite: etom_m.ctrl.regwrite,
                      memread: etom_m.ctrl.memread};

    // write-back
    assign w_result = mtow_w.ctrl.memread ? mtow_w.load_data : mtow_w.alu_result;
    assign wtoh_w   = '{dst: mtow_w.dst, regwrite: mtow_w.ctrl.regwrite};

    assign debug_wb_pc    = mtow_w.pc;
    assign debug_rf_wen   = mtow_w.ctrl.regwrite;
    assign debug_rf_wnum  = mtow_w.dst;
    assign debug_rf_wdata = w_result;

    // pipeline registers, flush leaves a zero nop behind
    always_ff @(posedge clk) begin
        if (!rst_n || flush.d) begin
            ftod_d <= '0;
        end else if (!stall.d) begin
            ftod_d <= ftod_f;
        end
        if (!rst_n || flush.e) begin
            dtoe_e <= '0;
        end else if (!stall.e) begin
            dtoe_e <= dtoe_d;
        end
        if (!rst_n || flush.m) begin
            etom_m <= '0;
        end else if (!stall.m) begin
            etom_m <= etom_e;
        end
        if (!rst_n || flush.w) begin
            mtow_w <= '0;
        end else if (!stall.w) begin
            mtow_w <= mtow_m;
        end
    end

endmodule

`default_nettype wire

// ==== verification/datapath_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath_sva (
    input wire logic               clk,
    input wire logic               rst_n,
    input wire pipe_pkg::word_t    pc,
    input wire pipe_pkg::stage_vec stall,
    input wire logic               data_req,
    input wire pipe_pkg::word_t    data_addr,
    input wire logic               debug_rf_wen,
    input wire isa_pkg::reg_idx_t  debug_rf_wnum
);

    int fail_count = 0;

    a_req_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        data_req |-> !$isunknown(data_addr))
        else begin
            fail_count++;
            $error("data request with unknown address");
        end

    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        debug_rf_wen |-> debug_rf_wnum != '0)
        else begin
            fail_count++;
            $error("write-back targets register 0");
        end

    // fetch stall freezes the pc for the next cycle
    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall.f |=> pc == $past(pc))
        else begin
            fail_count++;
            $error("pc changed while fetch was stalled");
        end

endmodule

bind datapath datapath_sva u_datapath_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc            (pc),
    .stall         (stall),
    .data_req      (data_req),
    .data_addr     (data_addr),
    .debug_rf_wen  (debug_rf_wen),
    .debug_rf_wnum (debug_rf_wnum)
);

`default_nettype wire

// ==== verification/tb_datapath.sv ====
`include "cpu_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_datapath;

    localparam int WB_TIMEOUT   = 16;
    localparam int DRAIN_CYCLES = 8;

    typedef struct packed {
        pipe_pkg::word_t   instr;
        logic              skip;
        isa_pkg::reg_idx_t rd;
        pipe_pkg::word_t   value;
    } row_t;

    logic              clk = 1'b0;
    logic              rst_n;
    pipe_pkg::word_t   instr;
    pipe_pkg::word_t   data_rdata;
    pipe_pkg::word_t   pc;
    logic              data_req;
    logic              data_wr;
    pipe_pkg::word_t   data_addr;
    pipe_pkg::word_t   data_wdata;
    pipe_pkg::word_t   debug_wb_pc;
    logic              debug_rf_wen;
    isa_pkg::reg_idx_t debug_rf_wnum;
    pipe_pkg::word_t   debug_rf_wdata;

    pipe_pkg::word_t   imem [64];
    pipe_pkg::word_t   dmem [256];
    row_t              prog [$];
    int                checks;
    int                value_errs;
    int                other_errs;

    always #4 clk = ~clk;

    datapath u_datapath (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr          (instr),
        .data_rdata     (data_rdata),
        .pc             (pc),
        .data_req       (data_req),
        .data_wr        (data_wr),
        .data_addr      (data_addr),
        .data_wdata     (data_wdata),
        .debug_wb_pc    (debug_wb_pc),
        .debug_rf_wen   (debug_rf_wen),
        .debug_rf_wnum  (debug_rf_wnum),
        .debug_rf_wdata (debug_rf_wdata)
    );

    // fetch and load both answer in the same cycle
    assign instr      = (pc[31:8] == '0) ? imem[pc[7:2]] : `NOP_WORD;
    assign data_rdata = dmem[data_addr[9:2]];

    always @(posedge clk) begin
        if (data_req && data_wr) begin
            dmem[data_addr[9:2]] <= data_wdata;
        end
    end

    function automatic pipe_pkg::word_t fill_word(input int unsigned addr);
        return 32'hc0de_0000 ^ addr;
    endfunction

    function automatic pipe_pkg::word_t enc_r(input isa_pkg::funct_e fn,
        input isa_pkg::reg_idx_t rs, input isa_pkg::reg_idx_t rt, input isa_pkg::reg_idx_t rd);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic pipe_pkg::word_t enc_i(input isa_pkg::opcode_e op,
        input isa_pkg::reg_idx_t rs, input isa_pkg::reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic pipe_pkg::word_t enc_j(input logic [25:0] target);
        return {isa_pkg::OP_J, target};
    endfunction

    task automatic add_write(input pipe_pkg::word_t iw, input isa_pkg::reg_idx_t rd,
        input pipe_pkg::word_t value);
        prog.push_back('{instr: iw, skip: 1'b0, rd: rd, value: value});
    endtask

    task automatic add_skip(input pipe_pkg::word_t iw);
        prog.push_back('{instr: iw, skip: 1'b1, rd: 5'd0, value: '0});
    endtask

    // row k sits at pc 4*k
    task automatic build_program();
        add_write(enc_i(isa_pkg::OP_ADDIU, 5'd0, 5'd1, 16'd5), 5'd1, 32'd5);
        add_write(enc_i(isa_pkg::OP_ADDIU, 5'd0, 5'd2, 16'd7), 5'd2, 32'd7);
        add_write(enc_i(isa_pkg::OP_LUI, 5'd0, 5'd3, 16'h1234), 5'd3, 32'h1234_0000);
        add_write(enc_r(isa_pkg::FN_OR, 5'd3, 5'd1, 5'd4), 5'd4, 32'h1234_0005);
        add_write(enc_r(isa_pkg::FN_ADDU, 5'd1, 5'd2, 5'd5), 5'd5, 32'd12);
        add_write(enc_r(isa_pkg::FN_SUBU, 5'd5, 5'd1, 5'd6), 5'd6, 32'd7);
        add_write(enc_r(isa_pkg::FN_SLT, 5'd1, 5'd6, 5'd7), 5'd7, 32'd1);
        add_write(enc_r(isa_pkg::FN_AND, 5'd5, 5'd6, 5'd8), 5'd8, 32'd4);
        add_write(enc_i(isa_pkg::OP_ADDIU, 5'd0, 5'd9, 16'h0040), 5'd9, 32'h40);
        add_skip(enc_i(isa_pkg::OP_SW, 5'd9, 5'd4, 16'd0));
        add_write(enc_i(isa_pkg::OP_LW, 5'd9, 5'd10, 16'd0), 5'd10, 32'h1234_0005);
        // load-use bubble
        add_write(enc_r(isa_pkg::FN_ADDU, 5'd10, 5'd1, 5'd11), 5'd11, 32'h1234_000a);
        add_write(enc_i(isa_pkg::OP_ADDIU, 5'd0, 5'd12, 16'hfffd), 5'd12, 32'hffff_fffd);
        add_write(enc_r(isa_pkg::FN_SLT, 5'd12, 5'd1, 5'd13), 5'd13, 32'd1);
        // beq on r13 right after its producer jumps to row 17
        add_skip(enc_i(isa_pkg::OP_BEQ, 5'd13, 5'd7, 16'd2));
        add_write(enc_i(isa_pkg::OP_ADDIU, 5'd0, 5'd14, 16'h0011), 5'd14, 32'h11);
        add_skip(enc_i(isa_pkg::OP_ADDIU, 5'd0, 5'd15, 16'h0099));
        add_skip(enc_i(isa_pkg::OP_BNE, 5'd1, 5'd1, 16'd4));
        add_write(enc_i(isa_pkg::OP_ADDIU, 5'd0, 5'd16, 16'h0022), 5'd16, 32'h22);
        add_write(enc_i(isa_pkg::OP_ADDIU, 5'd0, 5'd17, 16'h0033), 5'd17, 32'h33);
        add_skip(enc_j(26'd23));
        add_write(enc_i(isa_pkg::OP_ADDIU, 5'd14, 5'd18, 16'd1), 5'd18, 32'h12);
        add_skip(enc_i(isa_pkg::OP_ADDIU, 5'd0, 5'd19, 16'h0077));
        add_write(enc_i(isa_pkg::OP_LW, 5'd9, 5'd20, 16'd0), 5'd20, 32'h1234_0005);
        // branch waits for a load
        add_skip(enc_i(isa_pkg::OP_BNE, 5'd20, 5'd4, 16'd2));
        add_write(enc_i(isa_pkg::OP_ADDIU, 5'd0, 5'd21, 16'h0055), 5'd21, 32'h55);
        add_write(enc_r(isa_pkg::FN_SUBU, 5'd20, 5'd4, 5'd22), 5'd22, 32'd0);
        add_write(enc_i(isa_pkg::OP_LW, 5'd9, 5'd23, 16'd4), 5'd23, fill_word(17));
        // a write to r0 never shows up and r0 still reads zero
        add_skip(enc_i(isa_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h0055));
        add_write(enc_r(isa_pkg::FN_ADDU, 5'd0, 5'd1, 5'd24), 5'd24, 32'd5);
    endtask

    task automatic check_word(input string name, input pipe_pkg::word_t got,
        input pipe_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            value_errs++;
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input isa_pkg::reg_idx_t got,
        input isa_pkg::reg_idx_t exp);
        checks++;
        if (got !== exp) begin
            value_errs++;
            $display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    // outputs are sampled at the falling edge
    task automatic wait_wb(input logic quiet, output logic ok);
        int n;
        n = 0;
        @(negedge clk);
        while (debug_rf_wen !== 1'b1 && n < WB_TIMEOUT) begin
            if (quiet && data_req !== 1'b0) begin
                other_errs++;
                $display("data request at t=%0t before the first write-back", $time);
            end
            @(negedge clk);
            n++;
        end
        ok = (debug_rf_wen === 1'b1);
    endtask

    initial begin
        logic            ok;
        logic            timed_out;
        pipe_pkg::word_t exp_pc;
        int              sva_errs;
        rst_n      = 1'b0;
        checks     = 0;
        value_errs = 0;
        other_errs = 0;
        timed_out  = 1'b0;
        build_program();
        for (int k = 0; k < 64; k++) begin
            imem[k] = (k < prog.size()) ? prog[k].instr : `NOP_WORD;
        end
        for (int k = 0; k < 256; k++) begin
            dmem[k] = fill_word(k);
        end
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_word("pc", pc, `RESET_PC);
        if (debug_rf_wen !== 1'b0 || data_req !== 1'b0) begin
            other_errs++;
            $display("write-back or data request active right after reset");
        end
        for (int k = 0; k < prog.size() && !timed_out; k++) begin
            if (prog[k].skip) begin
                continue;
            end
            wait_wb(k == 0, ok);
            if (!ok) begin
                other_errs++;
                timed_out = 1'b1;
                $display("timeout waiting for the write-back of row %0d", k);
            end else begin
                exp_pc = `RESET_PC + 32'(k) * 32'd4;
                check_word("debug_wb_pc", debug_wb_pc, exp_pc);
                check_reg("debug_rf_wnum", debug_rf_wnum, prog[k].rd);
                check_word("debug_rf_wdata", debug_rf_wdata, prog[k].value);
            end
        end
        // nothing but nops follow
        if (!timed_out) begin
            repeat (DRAIN_CYCLES) begin
                @(negedge clk);
                if (debug_rf_wen !== 1'b0) begin
                    other_errs++;
                    $display("unexpected write-back from pc %h at t=%0t", debug_wb_pc, $time);
                end
            end
        end
        sva_errs = u_datapath.u_datapath_sva.fail_count;
        $display("checks=%0d value_errors=%0d other_errors=%0d assert_errors=%0d",
                 checks, value_errs, other_errs, sva_errs);
        if (value_errs == 0 && other_errs == 0 && sva_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/regfile.sv
src/decode.sv
src/hazard.sv
src/ex_stage.sv
src/datapath.sv
verification/datapath_sva.sv
verification/tb_datapath.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_datapath
FLIST     ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS := $(wildcard src/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
